/* Makefile */
VERILATOR ?= verilator
TOP       ?= tinker_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
FAIL_MSG  ?= FAIL: see errors above

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* exec_control.sv */
// Register values must hold from EXECUTE to WRITEBACK; unknown opcodes only advance the PC
`timescale 1ns/1ns

module exec_control (
    input  logic               clk,
    input  logic               reset,
    input  tinker_pkg::phase_t phase,
    input  tinker_pkg::addr_t  pc,
    output tinker_pkg::addr_t  next_pc,
    output logic               halt_seen,
    reg_port_if.control        regs,
    mem_port_if.data           mem
);
    tinker_pkg::instr_t  instr_q;
    tinker_pkg::word_t   result_q;      // ALU result, then load data
    tinker_pkg::addr_t   next_pc_q;
    tinker_pkg::opcode_t opcode;
    tinker_pkg::imm_t    imm;
    tinker_pkg::word_t   op1;
    tinker_pkg::word_t   alu_result;
    tinker_pkg::addr_t   mem_addr;
    tinker_pkg::addr_t   imm_sext;
    tinker_pkg::addr_t   branch_target;
    logic                imm_form;
    logic                writes_reg;
    logic                is_store;

    assign opcode      = instr_q[tinker_pkg::OPC_LSB +: tinker_pkg::OPC_W];
    assign regs.rd_idx = instr_q[tinker_pkg::RD_LSB +: tinker_pkg::REG_IDX_W];
    assign regs.rs_idx = instr_q[tinker_pkg::RS_LSB +: tinker_pkg::REG_IDX_W];
    assign regs.rt_idx = instr_q[tinker_pkg::RT_LSB +: tinker_pkg::REG_IDX_W];
    assign imm         = instr_q[tinker_pkg::L_LSB +: tinker_pkg::IMM_W];

    assign imm_form   = opcode inside {tinker_pkg::OP_ADDI, tinker_pkg::OP_SUBI,
                                       tinker_pkg::OP_SHFTRI, tinker_pkg::OP_SHFTLI,
                                       tinker_pkg::OP_MOVL};
    assign writes_reg = opcode inside {[tinker_pkg::OP_AND:tinker_pkg::OP_SHFTLI],
                                       tinker_pkg::OP_LOAD, tinker_pkg::OP_MOV,
                                       tinker_pkg::OP_MOVL,
                                       [tinker_pkg::OP_ADD:tinker_pkg::OP_SUBI]};
    assign is_store   = (opcode == tinker_pkg::OP_STORE);
    assign halt_seen  = (opcode == tinker_pkg::OP_HALT);

    assign op1 = imm_form ? regs.rd_val : regs.rs_val; // Immediate forms work on rd

    int_alu alu_inst (
        .opcode (opcode),
        .op1    (op1),
        .op2    (regs.rt_val),
        .imm    (imm),
        .result (alu_result)
    );

    // Base is rd for a store and rs for a load
    assign mem_addr = tinker_pkg::addr_t'(is_store ? regs.rd_val : regs.rs_val)
                    + tinker_pkg::addr_t'(imm);
    assign mem.load_addr  = mem_addr;
    assign mem.store_addr = mem_addr;
    assign mem.store_data = regs.rs_val;

    assign imm_sext = {{(tinker_pkg::ADDR_W - tinker_pkg::IMM_W){imm[tinker_pkg::IMM_W-1]}}, imm};

    always_comb begin
        branch_target = pc + tinker_pkg::addr_t'(4); // Fall through
        case (opcode)
            tinker_pkg::OP_BR:   branch_target = tinker_pkg::addr_t'(regs.rd_val);
            tinker_pkg::OP_BRR:  branch_target = pc + tinker_pkg::addr_t'(regs.rd_val);
            tinker_pkg::OP_BRRL: branch_target = pc + imm_sext;
            tinker_pkg::OP_BRNZ: begin
                if (regs.rs_val != '0) branch_target = tinker_pkg::addr_t'(regs.rd_val);
            end
            tinker_pkg::OP_BRGT: begin
                // Jump to the value in rd, signed compare
                if ($signed(regs.rs_val) > $signed(regs.rt_val)) begin
                    branch_target = tinker_pkg::addr_t'(regs.rd_val);
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            instr_q <= '0;
        end else if (phase == tinker_pkg::FETCH) begin
            instr_q <= mem.fetch_word;
        end
    end

    always_ff @(posedge clk) begin
        if (phase == tinker_pkg::EXECUTE) begin
            result_q <= alu_result;
        end
        if (phase == tinker_pkg::MEMORY) begin
            if (opcode == tinker_pkg::OP_LOAD) result_q <= mem.load_word;
            next_pc_q <= branch_target;
        end
    end

    assign next_pc = next_pc_q;

    // Strobes live for the WRITEBACK cycle only
    assign regs.wr_en   = (phase == tinker_pkg::WRITEBACK) && writes_reg;
    assign regs.wr_data = result_q;
    assign mem.store_we = (phase == tinker_pkg::WRITEBACK) && is_store;

endmodule

/* int_alu.sv */
// Shift amounts are used in full, so shifts by 64 or more give zero; unknown opcodes give zero
`timescale 1ns/1ns

module int_alu (
    input  tinker_pkg::opcode_t opcode,
    input  tinker_pkg::word_t   op1,
    input  tinker_pkg::word_t   op2,
    input  tinker_pkg::imm_t    imm,
    output tinker_pkg::word_t   result
);
    tinker_pkg::word_t imm_ext;

    assign imm_ext = tinker_pkg::word_t'(imm); // Zero extension

    always_comb begin
        case (opcode)
            tinker_pkg::OP_AND:    result = op1 & op2;
            tinker_pkg::OP_OR:     result = op1 | op2;
            tinker_pkg::OP_XOR:    result = op1 ^ op2;
            tinker_pkg::OP_NOT:    result = ~op1;      // rt unused
            tinker_pkg::OP_SHFTR:  result = op1 >> op2;
            tinker_pkg::OP_SHFTRI: result = op1 >> imm_ext;
            tinker_pkg::OP_SHFTL:  result = op1 << op2;
            tinker_pkg::OP_SHFTLI: result = op1 << imm_ext;
            tinker_pkg::OP_MOV:    result = op1;
            // Upper bits of rd survive
            tinker_pkg::OP_MOVL:   result = {op1[tinker_pkg::WORD_W-1:tinker_pkg::IMM_W], imm};
            tinker_pkg::OP_ADD:    result = op1 + op2;
            tinker_pkg::OP_ADDI:   result = op1 + imm_ext;
            tinker_pkg::OP_SUB:    result = op1 - op2;
            tinker_pkg::OP_SUBI:   result = op1 - imm_ext;
            default:               result = '0;
        endcase
    end

endmodule

/* phase_sequencer.sv */
// Fixed five-cycle instruction phases; HALTED is left only through reset
`timescale 1ns/1ns

module phase_sequencer (
    input  logic               clk,
    input  logic               reset,
    input  logic               halt_seen,
    output tinker_pkg::phase_t phase,
    output logic               hlt
);
    tinker_pkg::phase_t phase_next;

    always_comb begin
        case (phase)
            tinker_pkg::FETCH:     phase_next = tinker_pkg::DECODE;
            // Halt is caught once the instruction register holds it
            tinker_pkg::DECODE:    phase_next = halt_seen ? tinker_pkg::HALTED
                                                          : tinker_pkg::EXECUTE;
            tinker_pkg::EXECUTE:   phase_next = tinker_pkg::MEMORY;
            tinker_pkg::MEMORY:    phase_next = tinker_pkg::WRITEBACK;
            tinker_pkg::WRITEBACK: phase_next = tinker_pkg::FETCH;
            tinker_pkg::HALTED:    phase_next = tinker_pkg::HALTED; // Sticky
            default:               phase_next = tinker_pkg::FETCH;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            phase <= tinker_pkg::FETCH;
        end else begin
            phase <= phase_next;
        end
    end

    assign hlt = (phase == tinker_pkg::HALTED);

endmodule

/* program_counter.sv */
// PC changes only at the end of WRITEBACK; no alignment check on branch targets
`timescale 1ns/1ns

module program_counter #(
    parameter tinker_pkg::addr_t RESET_PC = '0
) (
    input  logic               clk,
    input  logic               reset,
    input  tinker_pkg::phase_t phase,
    input  tinker_pkg::addr_t  next_pc,
    output tinker_pkg::addr_t  pc,
    mem_port_if.fetch          mem
);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= RESET_PC;
        end else if (phase == tinker_pkg::WRITEBACK) begin
            pc <= next_pc; // Branch target or PC + 4
        end
    end

    // Memory sees the PC as the fetch address in every phase
    assign mem.fetch_addr = pc;

endmodule

/* register_file.sv */
// All 32 registers are general purpose and reset to zero; r31 gets no stack value
`timescale 1ns/1ns

module register_file (
    input  logic     clk,
    input  logic     reset,
    reg_port_if.file regs
);
    tinker_pkg::word_t regs_q [32];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (regs.wr_en) begin
            regs_q[regs.rd_idx] <= regs.wr_data; // Always to rd
        end
    end

    // Three independent read ports, no write bypass
    assign regs.rd_val = regs_q[regs.rd_idx];
    assign regs.rs_val = regs_q[regs.rs_idx];
    assign regs.rt_val = regs_q[regs.rt_idx];

endmodule

/* sources.f */
tinker_pkg.sv
tinker_ifs.sv
phase_sequencer.sv
program_counter.sv
register_file.sv
int_alu.sv
unified_memory.sv
exec_control.sv
tinker_core.sv
tinker_assert.sv
tinker_checker.sv
tinker_tb.sv

/* tinker_assert.sv */
// Commit and halt timing counted from reset; all checks are off while reset is high
`timescale 1ns/1ns

module tinker_assert (
    input logic               clk,
    input logic               reset,
    input tinker_pkg::phase_t phase,
    input logic               hlt,
    input logic               wb_valid,
    input logic               st_valid
);
    logic       commit;
    logic [2:0] slot;   // Cycle within the current instruction, counted from reset

    assign commit = wb_valid || st_valid;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            slot <= '0;
        end else begin
            slot <= (slot == 3'd4) ? 3'd0 : slot + 3'd1;
        end
    end

    one_commit_kind: assert property (@(posedge clk) disable iff (reset)
        !(wb_valid && st_valid)) else $error("wb_valid and st_valid high together");

    // Commits land only on every fifth cycle after reset
    commit_on_fifth_cycle: assert property (@(posedge clk) disable iff (reset)
        commit |-> slot == 3'd4) else $error("Commit off the five-cycle grid");

    writeback_on_fifth_cycle: assert property (@(posedge clk) disable iff (reset)
        slot == 3'd4 && !hlt |-> phase == tinker_pkg::WRITEBACK)
        else $error("WRITEBACK missing on its fifth cycle");

    halt_after_decode: assert property (@(posedge clk) disable iff (reset)
        $rose(hlt) |-> slot == 3'd2) else $error("hlt did not rise at the end of DECODE");

    halt_sticky: assert property (@(posedge clk) disable iff (reset)
        hlt |=> hlt && !commit) else $error("hlt dropped or commit while halted");

endmodule

/* tinker_checker.sv */
// Model memory is 4096 bytes, filled only from the load port; the model runs once when reset falls
`timescale 1ns/1ns

module tinker_checker (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 load_we,
    input  tinker_pkg::addr_t    load_addr,
    input  tinker_pkg::instr_t   load_data,
    input  logic                 hlt,
    input  logic                 wb_valid,
    input  tinker_pkg::reg_idx_t wb_reg,
    input  tinker_pkg::word_t    wb_data,
    input  logic                 st_valid,
    input  tinker_pkg::addr_t    st_addr,
    input  tinker_pkg::word_t    st_data,
    output int                   mismatches,
    output int                   extras,
    output int                   missing,
    output logic                 check_done
);
    localparam int MEM_BYTES = 4096;

    logic [7:0]        model_mem [MEM_BYTES];
    tinker_pkg::word_t regs [32];
    logic              exp_store [$]; // Store or register commit
    tinker_pkg::word_t exp_where [$]; // Address or register index
    tinker_pkg::word_t exp_data [$];

    initial begin
        mismatches = 0;
        extras = 0;
        missing = 0;
        check_done = 1'b0;
    end

    function automatic logic [11:0] byte_idx(input tinker_pkg::addr_t a, input int k);
        return 12'((a + 32'(k)) % 32'(MEM_BYTES));
    endfunction

    task automatic run_model();
        tinker_pkg::addr_t   pc;
        tinker_pkg::addr_t   nxt;
        tinker_pkg::addr_t   ea;
        tinker_pkg::instr_t  ins;
        tinker_pkg::opcode_t op;
        logic [4:0]          rd, rs, rt;
        tinker_pkg::word_t   rdv, rsv, rtv, l, res;
        logic                wr;
        pc = '0;
        for (int i = 0; i < 32; i++) regs[i] = '0;
        for (int n = 0; n < 1000; n++) begin
            for (int k = 0; k < 4; k++) ins[31-8*k -: 8] = model_mem[byte_idx(pc, k)];
            {op, rd, rs, rt} = ins[31:12];
            if (op == tinker_pkg::OP_HALT) return;
            l = 64'(ins[11:0]); // Zero extended literal
            rdv = regs[rd];
            rsv = regs[rs];
            rtv = regs[rt];
            wr = 1'b1;
            res = '0;
            nxt = pc + 32'd4;
            case (op)
                tinker_pkg::OP_AND:    res = rsv & rtv;
                tinker_pkg::OP_OR:     res = rsv | rtv;
                tinker_pkg::OP_XOR:    res = rsv ^ rtv;
                tinker_pkg::OP_NOT:    res = ~rsv;
                tinker_pkg::OP_SHFTR:  res = rsv >> rtv;
                tinker_pkg::OP_SHFTRI: res = rdv >> l;
                tinker_pkg::OP_SHFTL:  res = rsv << rtv;
                tinker_pkg::OP_SHFTLI: res = rdv << l;
                tinker_pkg::OP_MOV:    res = rsv;
                tinker_pkg::OP_MOVL:   res = {rdv[63:12], ins[11:0]};
                tinker_pkg::OP_ADD:    res = rsv + rtv;
                tinker_pkg::OP_ADDI:   res = rdv + l;
                tinker_pkg::OP_SUB:    res = rsv - rtv;
                tinker_pkg::OP_SUBI:   res = rdv - l;
                tinker_pkg::OP_LOAD: begin
                    ea = rsv[31:0] + l[31:0];
                    for (int k = 0; k < 8; k++) res[63-8*k -: 8] = model_mem[byte_idx(ea, k)];
                end
                tinker_pkg::OP_STORE: begin
                    ea = rdv[31:0] + l[31:0];
                    for (int k = 0; k < 8; k++) model_mem[byte_idx(ea, k)] = rsv[63-8*k -: 8];
                    exp_store.push_back(1'b1);
                    exp_where.push_back(64'(ea));
                    exp_data.push_back(rsv);
                    wr = 1'b0;
                end
                default: begin
                    wr = 1'b0; // Branches and unknown opcodes
                    case (op)
                        tinker_pkg::OP_BR:   nxt = rdv[31:0];
                        tinker_pkg::OP_BRR:  nxt = pc + rdv[31:0];
                        tinker_pkg::OP_BRRL: nxt = pc + {{20{ins[11]}}, ins[11:0]};
                        tinker_pkg::OP_BRNZ: if (rsv != '0) nxt = rdv[31:0];
                        tinker_pkg::OP_BRGT: if ($signed(rsv) > $signed(rtv)) nxt = rdv[31:0];
                        default: ;
                    endcase
                end
            endcase
            if (wr) begin
                regs[rd] = res;
                exp_store.push_back(1'b0);
                exp_where.push_back(64'(rd));
                exp_data.push_back(res);
            end
            pc = nxt;
        end
    endtask

    task automatic check_value(input string name, input tinker_pkg::word_t exp, got);
        if (got !== exp) begin
            mismatches++;
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, got);
        end
    endtask

    always @(negedge reset) run_model();

    always @(negedge clk) begin
        if (reset && load_we) begin
            for (int k = 0; k < 4; k++) model_mem[byte_idx(load_addr, k)] = load_data[31-8*k -: 8];
        end
        if (!reset && (wb_valid || st_valid)) begin
            if (hlt || exp_store.size() == 0) begin
                extras++;
                $display("Error at %0t: a commit appeared with no instruction left to commit",
                         $time);
            end else begin
                if (exp_store[0]) begin
                    check_value("st_valid", 64'd1, 64'(st_valid));
                    check_value("st_addr", exp_where[0], 64'(st_addr));
                    check_value("st_data", exp_data[0], st_data);
                end else begin
                    check_value("wb_valid", 64'd1, 64'(wb_valid));
                    check_value("wb_reg", exp_where[0], 64'(wb_reg));
                    check_value("wb_data", exp_data[0], wb_data);
                end
                void'(exp_store.pop_front());
                void'(exp_where.pop_front());
                void'(exp_data.pop_front());
            end
        end
        if (check_done && !hlt) check_value("hlt", 64'd1, 64'(hlt)); // Must stay high
        if (!reset && hlt && !check_done) begin
            missing = exp_store.size();
            if (missing != 0) begin
                $display("Error at %0t: core halted with %0d expected commits never seen",
                         $time, missing);
            end
            check_done = 1'b1;
        end
    end

endmodule

/* tinker_core.sv */
// Every instruction takes five cycles; load port is for program fill while reset is high
`timescale 1ns/1ns

module tinker_core #(
    parameter int                MEM_BYTES = 4096,
    parameter tinker_pkg::addr_t RESET_PC  = '0
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 load_we,
    input  tinker_pkg::addr_t    load_addr,
    input  tinker_pkg::instr_t   load_data,
    output logic                 hlt,
    output logic                 wb_valid,   // Register write commit
    output tinker_pkg::reg_idx_t wb_reg,
    output tinker_pkg::word_t    wb_data,
    output logic                 st_valid,   // Store commit
    output tinker_pkg::addr_t    st_addr,
    output tinker_pkg::word_t    st_data
);
    tinker_pkg::phase_t phase;
    tinker_pkg::addr_t  pc;
    tinker_pkg::addr_t  next_pc;
    logic               halt_seen;

    mem_port_if mem_if ();
    reg_port_if reg_if ();

    phase_sequencer sequencer_inst (
        .clk       (clk),
        .reset     (reset),
        .halt_seen (halt_seen),
        .phase     (phase),
        .hlt       (hlt)
    );

    program_counter #(.RESET_PC(RESET_PC)) pc_inst (
        .clk     (clk),
        .reset   (reset),
        .phase   (phase),
        .next_pc (next_pc),
        .pc      (pc),
        .mem     (mem_if.fetch)
    );

    register_file regfile_inst (
        .clk   (clk),
        .reset (reset),
        .regs  (reg_if.file)
    );

    unified_memory #(.MEM_BYTES(MEM_BYTES)) memory_inst (
        .clk       (clk),
        .load_we   (load_we),
        .load_addr (load_addr),
        .load_data (load_data),
        .mem       (mem_if.memory)
    );

    exec_control control_inst (
        .clk       (clk),
        .reset     (reset),
        .phase     (phase),
        .pc        (pc),
        .next_pc   (next_pc),
        .halt_seen (halt_seen),
        .regs      (reg_if.control),
        .mem       (mem_if.data)
    );

    assign wb_valid = reg_if.wr_en;
    assign wb_reg   = reg_if.rd_idx;
    assign wb_data  = reg_if.wr_data;
    assign st_valid = mem_if.store_we;
    assign st_addr  = mem_if.store_addr;
    assign st_data  = mem_if.store_data;

endmodule

/* tinker_ifs.sv */
// Both ports are unclocked bundles; memory and register reads through them are combinational
`timescale 1ns/1ns

interface mem_port_if;
    tinker_pkg::addr_t  fetch_addr;
    tinker_pkg::instr_t fetch_word;
    tinker_pkg::addr_t  load_addr;
    tinker_pkg::word_t  load_word;
    logic               store_we;   // One cycle, writes 8 bytes
    tinker_pkg::addr_t  store_addr;
    tinker_pkg::word_t  store_data;

    modport fetch  (output fetch_addr);
    modport data   (input fetch_word, load_word,
                    output load_addr, store_we, store_addr, store_data);
    modport memory (input fetch_addr, load_addr, store_we, store_addr, store_data,
                    output fetch_word, load_word);
endinterface

interface reg_port_if;
    tinker_pkg::reg_idx_t rd_idx;   // Also the write index
    tinker_pkg::reg_idx_t rs_idx;
    tinker_pkg::reg_idx_t rt_idx;
    logic                 wr_en;
    tinker_pkg::word_t    wr_data;
    tinker_pkg::word_t    rd_val;
    tinker_pkg::word_t    rs_val;
    tinker_pkg::word_t    rt_val;

    modport control (output rd_idx, rs_idx, rt_idx, wr_en, wr_data,
                     input rd_val, rs_val, rt_val);
    modport file    (input rd_idx, rs_idx, rt_idx, wr_en, wr_data,
                     output rd_val, rs_val, rt_val);
endinterface

/* tinker_pkg.sv */
// Tinker integer subset only; no floating point, mul, div, call or return; addresses are 32 bits
package tinker_pkg;

    localparam int WORD_W    = 64;
    localparam int ADDR_W    = 32;
    localparam int INSTR_W   = 32;
    localparam int REG_IDX_W = 5;
    localparam int IMM_W     = 12;
    localparam int OPC_W     = 5;

    typedef logic [WORD_W-1:0]    word_t;
    typedef logic [ADDR_W-1:0]    addr_t;
    typedef logic [INSTR_W-1:0]   instr_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [IMM_W-1:0]     imm_t;
    typedef logic [OPC_W-1:0]     opcode_t;

    // Low bit of each instruction field
    localparam int OPC_LSB = 27;
    localparam int RD_LSB  = 22;
    localparam int RS_LSB  = 17;
    localparam int RT_LSB  = 12;
    localparam int L_LSB   = 0;

    localparam opcode_t OP_AND    = 5'h00;
    localparam opcode_t OP_OR     = 5'h01;
    localparam opcode_t OP_XOR    = 5'h02;
    localparam opcode_t OP_NOT    = 5'h03;
    localparam opcode_t OP_SHFTR  = 5'h04;
    localparam opcode_t OP_SHFTRI = 5'h05;
    localparam opcode_t OP_SHFTL  = 5'h06;
    localparam opcode_t OP_SHFTLI = 5'h07;
    localparam opcode_t OP_BR     = 5'h08;
    localparam opcode_t OP_BRR    = 5'h09;
    localparam opcode_t OP_BRRL   = 5'h0a;
    localparam opcode_t OP_BRNZ   = 5'h0b;
    localparam opcode_t OP_BRGT   = 5'h0e;
    localparam opcode_t OP_HALT   = 5'h0f;
    localparam opcode_t OP_LOAD   = 5'h10; // mov rd, (rs)(L)
    localparam opcode_t OP_MOV    = 5'h11;
    localparam opcode_t OP_MOVL   = 5'h12; // Low 12 bits of rd only
    localparam opcode_t OP_STORE  = 5'h13; // mov (rd)(L), rs
    localparam opcode_t OP_ADD    = 5'h18;
    localparam opcode_t OP_ADDI   = 5'h19;
    localparam opcode_t OP_SUB    = 5'h1a;
    localparam opcode_t OP_SUBI   = 5'h1b;

    typedef enum logic [2:0] {
        FETCH,
        DECODE,
        EXECUTE,
        MEMORY,
        WRITEBACK,
        HALTED
    } phase_t;

endpackage

/* tinker_tb.sv */
// Reset stays high while the program and data region load, then 10 more cycles; fixed LFSR seed
`timescale 1ns/1ns

module tinker_tb;
    localparam int MAX_INSTR  = 64;
    localparam int DATA_BASE  = 'h400;
    localparam int DATA_WORDS = 16;  // 64 bytes, eight load or store slots
    localparam int RESET_TAIL = 10;
    localparam tinker_pkg::opcode_t ALU_OPS [14] = '{
        tinker_pkg::OP_AND, tinker_pkg::OP_OR, tinker_pkg::OP_XOR, tinker_pkg::OP_NOT,
        tinker_pkg::OP_SHFTR, tinker_pkg::OP_SHFTRI, tinker_pkg::OP_SHFTL, tinker_pkg::OP_SHFTLI,
        tinker_pkg::OP_MOV, tinker_pkg::OP_MOVL, tinker_pkg::OP_ADD, tinker_pkg::OP_ADDI,
        tinker_pkg::OP_SUB, tinker_pkg::OP_SUBI};

    logic                 clk = 1'b0;
    logic                 reset;
    logic                 load_we;
    tinker_pkg::addr_t    load_addr;
    tinker_pkg::instr_t   load_data;
    logic                 hlt, wb_valid, st_valid;
    tinker_pkg::reg_idx_t wb_reg;
    tinker_pkg::word_t    wb_data, st_data;
    tinker_pkg::addr_t    st_addr;
    tinker_pkg::instr_t   prog [MAX_INSTR];
    int                   prog_len = 0;
    logic [31:0]          lfsr = 32'hbcb7;
    int                   mismatches, extras, missing;
    logic                 check_done;

    always #5 clk = ~clk;

    tinker_core tinker_core_inst (.*);
    tinker_checker checker_inst (.*);

    bind tinker_core tinker_assert assert_inst (.clk(clk), .reset(reset), .phase(phase),
        .hlt(hlt), .wb_valid(wb_valid), .st_valid(st_valid));

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic tinker_pkg::instr_t encode(input tinker_pkg::opcode_t op,
            input logic [4:0] rd, rs, rt, input logic [11:0] l);
        return {op, rd, rs, rt, l};
    endfunction

    function automatic tinker_pkg::instr_t random_alu();
        tinker_pkg::opcode_t op;
        logic [11:0]         l;
        op = ALU_OPS[take_bits(4) % 14];
        // Short immediate shifts so results are not always zero
        l = (op == tinker_pkg::OP_SHFTRI || op == tinker_pkg::OP_SHFTLI) ? 12'(take_bits(6))
                                                                         : 12'(take_bits(12));
        return encode(op, 5'(take_bits(5)), 5'(take_bits(5)), 5'(take_bits(5)), l);
    endfunction

    task automatic emit(input tinker_pkg::instr_t w);
        prog[prog_len] = w;
        prog_len++;
    endtask

    task automatic build_program();
        logic [3:0] kind;
        logic [4:0] r;  // Base or target register
        int         skip;
        while (prog_len < MAX_INSTR - 8) begin
            kind = 4'(take_bits(4));
            r = 5'(take_bits(5));
            skip = int'(take_bits(2));
            case (kind)
                6, 7: begin
                    emit(encode(tinker_pkg::OP_XOR, r, r, r, 12'd0)); // Clear the base
                    emit(encode(tinker_pkg::OP_MOVL, r, 5'd0, 5'd0, 12'(DATA_BASE)));
                    if (kind == 6) begin
                        emit(encode(tinker_pkg::OP_STORE, r, 5'(take_bits(5)), 5'd0,
                                    12'(8 * take_bits(3))));
                    end else begin
                        emit(encode(tinker_pkg::OP_LOAD, 5'(take_bits(5)), r, 5'd0,
                                    12'(8 * take_bits(3))));
                    end
                end
                8, 11, 12: begin
                    emit(encode(tinker_pkg::OP_XOR, r, r, r, 12'd0));
                    // Absolute target just past the skipped block
                    emit(encode(tinker_pkg::OP_MOVL, r, 5'd0, 5'd0, 12'(4 * (prog_len + 2 + skip))));
                    emit(encode(kind == 8 ? tinker_pkg::OP_BR :
                                kind == 11 ? tinker_pkg::OP_BRNZ : tinker_pkg::OP_BRGT,
                                r, 5'(take_bits(5)), 5'(take_bits(5)), 12'd0));
                    repeat (skip) emit(random_alu());
                end
                9: begin
                    emit(encode(tinker_pkg::OP_XOR, r, r, r, 12'd0));
                    emit(encode(tinker_pkg::OP_MOVL, r, 5'd0, 5'd0, 12'(4 * (1 + skip))));
                    emit(encode(tinker_pkg::OP_BRR, r, 5'd0, 5'd0, 12'd0));
                    repeat (skip) emit(random_alu());
                end
                10: begin
                    emit(encode(tinker_pkg::OP_BRRL, 5'd0, 5'd0, 5'd0, 12'(4 * (1 + skip))));
                    repeat (skip) emit(random_alu());
                end
                default: emit(random_alu());
            endcase
        end
        emit(encode(tinker_pkg::OP_HALT, 5'd0, 5'd0, 5'd0, 12'd0));
    endtask

    initial begin
        tinker_pkg::addr_t a;
        reset = 1'b1;
        load_we = 1'b0;
        load_addr = '0;
        load_data = '0;
        build_program();
        for (int i = 0; i < prog_len + DATA_WORDS; i++) begin
            @(posedge clk);
            a = (i < prog_len) ? 32'(4 * i) : 32'(DATA_BASE + 4 * (i - prog_len));
            load_we <= 1'b1;
            load_addr <= a;
            // Data fill mixes every address bit
            load_data <= (i < prog_len) ? prog[i] : a ^ {a[15:0], a[31:16]} ^ 32'h2545_f491;
        end
        @(posedge clk);
        load_we <= 1'b0;
        repeat (RESET_TAIL) @(posedge clk);
        reset <= 1'b0;
        wait (check_done === 1'b1);
        repeat (5) @(posedge clk); // Window for stray commits after halt
        $display("Checks done: %0d mismatches, %0d unexpected commits, %0d missing commits",
                 mismatches, extras, missing);
        if (mismatches + extras + missing == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // Limit follows program length, load time and reset
    initial begin
        #1;
        #((prog_len * 5 + prog_len + DATA_WORDS + 1 + RESET_TAIL + 200) * 10);
        $display("Timeout: the core did not halt in time (%0d mismatches so far)", mismatches);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

/* unified_memory.sv */
// Contents survive reset; addresses wrap modulo MEM_BYTES; program load only meant for reset time
`timescale 1ns/1ns

module unified_memory #(
    parameter int MEM_BYTES = 4096
) (
    input  logic               clk,
    input  logic               load_we,
    input  tinker_pkg::addr_t  load_addr,
    input  tinker_pkg::instr_t load_data,
    mem_port_if.memory         mem
);
    localparam int IDX_W = $clog2(MEM_BYTES);

    logic [7:0] bytes [MEM_BYTES];
    tinker_pkg::instr_t fetch_word;
    tinker_pkg::word_t  load_word;

    // Byte index of base + off after wrapping
    function automatic logic [IDX_W-1:0] wrap(input tinker_pkg::addr_t base,
                                              input int unsigned off);
        tinker_pkg::addr_t a;
        a = base + tinker_pkg::addr_t'(off);
        return IDX_W'(a % MEM_BYTES);
    endfunction

    always_ff @(posedge clk) begin
        if (load_we) begin
            for (int k = 0; k < 4; k++) begin
                bytes[wrap(load_addr, k)] <= load_data[31-8*k -: 8];
            end
        end
        if (mem.store_we) begin
            for (int k = 0; k < 8; k++) begin
                bytes[wrap(mem.store_addr, k)] <= mem.store_data[63-8*k -: 8]; // MSB first
            end
        end
    end

    // Big-endian reads, lowest address is the most significant byte
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            fetch_word[31-8*k -: 8] = bytes[wrap(mem.fetch_addr, k)];
        end
        for (int k = 0; k < 8; k++) begin
            load_word[63-8*k -: 8] = bytes[wrap(mem.load_addr, k)];
        end
    end

    assign mem.fetch_word = fetch_word;
    assign mem.load_word  = load_word;

endmodule
